// File: verilog.f
+incdir+source
source/cache_pkg.sv
source/cache_tag_decode.sv
source/cache_line_exec.sv
source/cache_word_result.sv
source/line_memory.sv
source/cache_top.sv
bench/tb_cache_top.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module tb_cache_top \
	-Mdir obj_dir -o sim_cache

./obj_dir/sim_cache | tee sim.log

if grep -q "^All checks passed$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: bench/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_cache_top;
	import cache_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int BYTE_W = $clog2(`WORD_W / 8);
	localparam int MEM_WORDS = 2 ** (`ADDR_W - BYTE_W);
	// a write-through alone stalls under this and a fill plus write-through over it
	localparam int WRITE_HIT_MAX = 2 * `MEM_LATENCY + 2;
	localparam int RANDOM_ACCESSES = 40;

	typedef struct packed {
		logic               write;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
		logic [`WORD_W-1:0] exp_rdata;
		logic               exp_hit;
	} entry_t;

	logic               CLK;
	logic               arst_n;
	logic               cpu_sel;
	cpu_req_t           cpu_req;
	logic [`WORD_W-1:0] rdata;
	logic               stall;

	entry_t             stim_q[$];
	logic [`WORD_W-1:0] shadow_mem [MEM_WORDS];
	logic               shadow_valid [`CACHE_LINES];
	logic [`TAG_W-1:0]  shadow_tag [`CACHE_LINES];
	integer             seed = 4607;
	int                 cycles = 0;
	int                 limit = 0;
	int                 data_errors = 0;
	int                 hit_errors = 0;
	int                 other_errors = 0;

	cache_top u_dut (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.cpu_sel (cpu_sel),
		.cpu_req (cpu_req),
		.rdata   (rdata),
		.stall   (stall)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic report_and_finish();
		$display("errors: data %0d, hit %0d, other %0d", data_errors, hit_errors, other_errors);
		if (data_errors + hit_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	always @(posedge CLK) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			other_errors++;
			$display("timeout: the run did not finish within %0d cycles", limit);
			report_and_finish();
		end
	end

	// reference model of the memory image and the tag directory
	task automatic add_entry(input logic write, input logic [`ADDR_W-1:0] addr,
		input logic [`WORD_W-1:0] wdata);
		entry_t            e;
		logic [`IDX_W-1:0] ix;
		logic [`TAG_W-1:0] tg;
		int                widx;
		ix = addr[BYTE_W + `OFF_W +: `IDX_W];
		tg = addr[`ADDR_W-1 -: `TAG_W];
		widx = int'(addr[`ADDR_W-1:BYTE_W]);
		e.write = write;
		e.addr = addr;
		e.wdata = wdata;
		e.exp_hit = shadow_valid[ix] && (shadow_tag[ix] == tg);
		// both miss kinds allocate
		shadow_valid[ix] = 1'b1;
		shadow_tag[ix] = tg;
		if (write) begin
			shadow_mem[widx] = wdata;
		end
		e.exp_rdata = shadow_mem[widx];
		stim_q.push_back(e);
	endtask

	task automatic build_table();
		int                r;
		logic [`TAG_W-1:0] tg;
		for (int w = 0; w < MEM_WORDS; w++) begin
			shadow_mem[w] = 32'(w) ^ 32'hC0DE0000;
		end
		for (int l = 0; l < `CACHE_LINES; l++) begin
			shadow_valid[l] = 1'b0;
			shadow_tag[l] = '0;
		end
		// first touch misses
		add_entry(1'b0, 12'h134, '0);
		// same line at every offset
		add_entry(1'b0, 12'h138, '0);
		add_entry(1'b0, 12'h130, '0);
		add_entry(1'b0, 12'h13C, '0);
		add_entry(1'b0, 12'h134, '0);
		// write hit leaves the neighbours untouched
		add_entry(1'b1, 12'h138, 32'hDEADBEEF);
		add_entry(1'b0, 12'h138, '0);
		add_entry(1'b0, 12'h130, '0);
		add_entry(1'b0, 12'h13C, '0);
		add_entry(1'b0, 12'h134, '0);
		// write miss allocates
		add_entry(1'b1, 12'h2A4, 32'h12345678);
		add_entry(1'b0, 12'h2A0, '0);
		add_entry(1'b0, 12'h2AC, '0);
		add_entry(1'b0, 12'h2A4, '0);
		// same index and other tag, then back
		add_entry(1'b0, 12'h1B8, '0);
		add_entry(1'b0, 12'h138, '0);
		add_entry(1'b0, 12'h3A0, '0);
		add_entry(1'b0, 12'h2A4, '0);
		// two tags over all indices
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			r = $random(seed);
			tg = r[0] ? 5'h1B : 5'h04;
			add_entry(r[8], {tg, r[6:4], r[3:2], {BYTE_W{1'b0}}}, $random(seed));
		end
	endtask

	task automatic run_access(input int n);
		entry_t             e;
		int                 stall_cycles;
		logic               done;
		logic               got_hit;
		logic [`WORD_W-1:0] got;
		e = stim_q[n];
		cpu_sel = 1'b1;
		cpu_req.write = e.write;
		cpu_req.addr = e.addr;
		cpu_req.wdata = e.wdata;
		stall_cycles = 0;
		done = 1'b0;
		got = '0;
		while (!done) begin
			@(negedge CLK);
			if (!stall) begin
				done = 1'b1;
				got = rdata;
			end else begin
				stall_cycles++;
			end
			@(posedge CLK);
		end
		#2;
		cpu_sel = 1'b0;
		cpu_req = '0;
		if (!e.write && got !== e.exp_rdata) begin
			$display("FAIL entry %0d addr %h: rdata got %h exp %h", n, e.addr, got, e.exp_rdata);
			data_errors++;
		end
		if (e.write && stall_cycles == 0) begin
			$display("entry %0d: write at %h completed without any stall", n, e.addr);
			other_errors++;
		end
		if (e.write) begin
			got_hit = (stall_cycles <= WRITE_HIT_MAX);
		end else begin
			got_hit = (stall_cycles == 0);
		end
		if (got_hit !== e.exp_hit) begin
			$display("FAIL entry %0d addr %h: hit got %h exp %h (%0d stall cycles)",
				n, e.addr, got_hit, e.exp_hit, stall_cycles);
			hit_errors++;
		end
		// idle cycle between accesses
		@(negedge CLK);
		if (stall) begin
			$display("stall is high while cpu_sel is low after entry %0d", n);
			other_errors++;
		end
		@(posedge CLK);
		#2;
	endtask

	initial begin
		cpu_sel = 1'b0;
		cpu_req = '0;
		arst_n = 1'b0;
		build_table();
		limit = stim_q.size() * (2 * `MEM_LATENCY + 10) + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		arst_n = 1'b1;
		@(negedge CLK);
		if (stall) begin
			$display("stall is high after reset with cpu_sel low");
			other_errors++;
		end
		@(posedge CLK);
		#2;
		for (int i = 0; i < stim_q.size(); i++) begin
			run_access(i);
		end
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: source/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_top (
	input  wire logic               CLK,
	input  wire logic               arst_n,
	input  wire logic               cpu_sel,
	input  var  cache_pkg::cpu_req_t cpu_req,
	output logic [`WORD_W-1:0]      rdata,
	output logic                    stall
);
	import cache_pkg::*;

	cache_op_e          op;
	logic [`IDX_W-1:0]  idx;
	logic [`TAG_W-1:0]  tag;
	logic [`OFF_W-1:0]  off;
	tag_upd_t           tag_upd;
	logic [`LINE_W-1:0] cur_line;
	logic [`LINE_W-1:0] merged_line;
	logic [`LINE_W-1:0] rline;
	logic               mem_req;
	logic               mem_ack;
	mem_req_t           mem_cmd;

	cache_tag_decode u_decode (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.cpu_sel (cpu_sel),
		.cpu_req (cpu_req),
		.tag_upd (tag_upd),
		.op      (op),
		.idx     (idx),
		.tag     (tag),
		.off     (off)
	);

	cache_line_exec u_exec (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.cpu_sel     (cpu_sel),
		.cpu_req     (cpu_req),
		.op          (op),
		.idx         (idx),
		.tag         (tag),
		.merged_line (merged_line),
		.cur_line    (cur_line),
		.tag_upd     (tag_upd),
		.stall       (stall),
		.mem_req     (mem_req),
		.mem_cmd     (mem_cmd),
		.mem_ack     (mem_ack),
		.rline       (rline)
	);

	cache_word_result u_result (
		.cur_line    (cur_line),
		.off         (off),
		.wdata       (cpu_req.wdata),
		.rdata       (rdata),
		.merged_line (merged_line)
	);

	line_memory u_mem (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.mem_req (mem_req),
		.mem_cmd (mem_cmd),
		.mem_ack (mem_ack),
		.rline   (rline)
	);

endmodule

`default_nettype wire

// File: source/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module line_memory (
	input  wire logic               CLK,
	input  wire logic               arst_n,
	input  wire logic               mem_req,
	input  var  cache_pkg::mem_req_t mem_cmd,
	output logic                    mem_ack,
	output logic [`LINE_W-1:0]      rline
);

	localparam int MEM_LINES = 2 ** `LINE_ADDR_W;
	localparam int WORDS = `LINE_W / `WORD_W;
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	logic [`LINE_W-1:0] mem [MEM_LINES];
	logic [CNT_W-1:0]   cnt;
	logic               fire;

	// word w holds w ^ C0DE0000 at start
	initial begin
		for (int l = 0; l < MEM_LINES; l++) begin
			for (int w = 0; w < WORDS; w++) begin
				mem[l][`LINE_W-1 - w*`WORD_W -: `WORD_W] = 32'(l*WORDS + w) ^ 32'hC0DE0000;
			end
		end
	end

	// last wait cycle before ack
	assign fire = mem_req && !mem_ack && (cnt == CNT_W'(`MEM_LATENCY - 1));

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			mem_ack <= 1'b0;
		end else if (!mem_req) begin
			// release one cycle after req drops
			cnt <= '0;
			mem_ack <= 1'b0;
		end else if (fire) begin
			mem_ack <= 1'b1;
		end else if (!mem_ack) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (fire) begin
			if (mem_cmd.write) begin
				mem[mem_cmd.line_addr] <= mem_cmd.wline;
			end
			rline <= mem[mem_cmd.line_addr];
		end
	end

endmodule

`default_nettype wire

// File: source/cache_word_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_word_result (
	input  wire logic [`LINE_W-1:0] cur_line,
	input  wire logic [`OFF_W-1:0]  off,
	input  wire logic [`WORD_W-1:0] wdata,
	output logic [`WORD_W-1:0]      rdata,
	output logic [`LINE_W-1:0]      merged_line
);

	localparam int WORDS = `LINE_W / `WORD_W;

	// word 0 sits in the top bits of the line
	always_comb begin
		rdata = '0;
		merged_line = cur_line;
		for (int w = 0; w < WORDS; w++) begin
			if (off == `OFF_W'(w)) begin
				rdata = cur_line[`LINE_W-1 - w*`WORD_W -: `WORD_W];
				merged_line[`LINE_W-1 - w*`WORD_W -: `WORD_W] = wdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/cache_line_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_line_exec (
	input  wire logic                CLK,
	input  wire logic                arst_n,
	input  wire logic                cpu_sel,
	input  var  cache_pkg::cpu_req_t  cpu_req,
	input  var  cache_pkg::cache_op_e op,
	input  wire logic [`IDX_W-1:0]   idx,
	input  wire logic [`TAG_W-1:0]   tag,
	input  wire logic [`LINE_W-1:0]  merged_line,
	output logic [`LINE_W-1:0]       cur_line,
	output cache_pkg::tag_upd_t      tag_upd,
	output logic                     stall,
	output logic                     mem_req,
	output cache_pkg::mem_req_t      mem_cmd,
	input  wire logic                mem_ack,
	input  wire logic [`LINE_W-1:0]  rline
);
	import cache_pkg::*;

	exec_state_e        state;
	exec_state_e        state_nxt;
	logic [`LINE_W-1:0] data_arr [`CACHE_LINES];
	logic               arr_we;
	logic [`LINE_W-1:0] arr_wdata;
	logic               cmd_load;
	mem_req_t           cmd_nxt;

	assign cur_line = data_arr[idx];

	// request is held for the whole fill or write-through
	assign mem_req = (state == ST_FILL) || (state == ST_WT);

	always_comb begin
		state_nxt = state;
		stall = 1'b1;
		arr_we = 1'b0;
		arr_wdata = rline;
		cmd_load = 1'b0;
		cmd_nxt.write = 1'b0;
		cmd_nxt.line_addr = cpu_req.addr[`ADDR_W-1 -: `LINE_ADDR_W];
		cmd_nxt.wline = '0;
		tag_upd.en = 1'b0;
		tag_upd.idx = idx;
		tag_upd.tag = tag;
		tag_upd.valid = 1'b1;

		case (state)
			ST_IDLE: begin
				stall = 1'b0;
				if (cpu_sel) begin
					case (op)
						OP_READ_MISS, OP_WRITE_MISS: begin
							// allocate first so write misses come back as hits
							stall = 1'b1;
							cmd_load = 1'b1;
							state_nxt = ST_FILL;
						end
						OP_WRITE_HIT: begin
							stall = 1'b1;
							arr_we = 1'b1;
							arr_wdata = merged_line;
							cmd_load = 1'b1;
							cmd_nxt.write = 1'b1;
							cmd_nxt.wline = merged_line;
							state_nxt = ST_WT;
						end
						default: begin
							state_nxt = ST_IDLE;
						end
					endcase
				end
			end
			ST_FILL: begin
				// line and tag land together on the first ack cycle
				if (mem_ack) begin
					arr_we = 1'b1;
					tag_upd.en = 1'b1;
					state_nxt = ST_FILL_REL;
				end
			end
			ST_FILL_REL: begin
				if (!mem_ack) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_WT: begin
				if (mem_ack) begin
					state_nxt = ST_WT_REL;
				end
			end
			ST_WT_REL: begin
				if (!mem_ack) begin
					state_nxt = ST_DONE;
				end
			end
			ST_DONE: begin
				// write completes here
				stall = 1'b0;
				state_nxt = ST_IDLE;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge CLK) begin
		if (arr_we) begin
			data_arr[idx] <= arr_wdata;
		end
	end

	always_ff @(posedge CLK) begin
		if (cmd_load) begin
			mem_cmd <= cmd_nxt;
		end
	end

	// four-phase rules toward line_memory
	a_req_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		mem_req && !mem_ack |=> mem_req && $stable(mem_cmd));

	a_req_after_ack_low: assert property (@(posedge CLK) disable iff (!arst_n)
		$rose(mem_req) |-> !mem_ack);

endmodule

`default_nettype wire

// File: source/cache_tag_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tag_decode (
	input  wire logic               CLK,
	input  wire logic               arst_n,
	input  wire logic               cpu_sel,
	input  var  cache_pkg::cpu_req_t cpu_req,
	input  var  cache_pkg::tag_upd_t tag_upd,
	output cache_pkg::cache_op_e    op,
	output logic [`IDX_W-1:0]       idx,
	output logic [`TAG_W-1:0]       tag,
	output logic [`OFF_W-1:0]       off
);
	import cache_pkg::*;

	localparam int BYTE_W = $clog2(`WORD_W / 8);

	logic [`TAG_W-1:0]       tag_arr [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid;
	logic                    hit;

	// tag | index | word offset | byte
	assign off = cpu_req.addr[BYTE_W +: `OFF_W];
	assign idx = cpu_req.addr[BYTE_W + `OFF_W +: `IDX_W];
	assign tag = cpu_req.addr[`ADDR_W-1 -: `TAG_W];

	assign hit = valid[idx] && (tag_arr[idx] == tag);

	always_comb begin
		if (!cpu_sel) begin
			op = OP_NONE;
		end else if (cpu_req.write) begin
			op = hit ? OP_WRITE_HIT : OP_WRITE_MISS;
		end else begin
			op = hit ? OP_READ_HIT : OP_READ_MISS;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (tag_upd.en) begin
			valid[tag_upd.idx] <= tag_upd.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (tag_upd.en) begin
			tag_arr[tag_upd.idx] <= tag_upd.tag;
		end
	end

	// a line must never turn valid with a garbage tag
	a_upd_tag_known: assert property (@(posedge CLK) disable iff (!arst_n)
		tag_upd.en && tag_upd.valid |-> !$isunknown(tag_upd.tag));

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

	// what the processor presents while cpu_sel is high
	typedef struct packed {
		logic               write;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
	} cpu_req_t;

	// line transfer command that travels with mem_req
	typedef struct packed {
		logic                    write;
		logic [`LINE_ADDR_W-1:0] line_addr;
		logic [`LINE_W-1:0]      wline;
	} mem_req_t;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_READ_HIT,
		OP_READ_MISS,
		OP_WRITE_HIT,
		OP_WRITE_MISS
	} cache_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FILL,
		ST_FILL_REL,
		ST_WT,
		ST_WT_REL,
		ST_DONE
	} exec_state_e;

	// directory update from the controller
	typedef struct packed {
		logic              en;
		logic [`IDX_W-1:0] idx;
		logic [`TAG_W-1:0] tag;
		logic              valid;
	} tag_upd_t;

endpackage

`default_nettype wire

// File: source/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_LINES 8
`define IDX_W 3
`define TAG_W 5
`define OFF_W 2

// address and data widths
`define ADDR_W 12
`define WORD_W 32
`define LINE_W 128
`define LINE_ADDR_W 8

// cycles from mem_req rising to mem_ack
`define MEM_LATENCY 4

`endif
